// ==== test/fpu_trace.txt ====
# op sub_op frm csr_frm op1 op2 waddr commit_id exp_data exp_flags backpressure (all hex)
# op bits: 40 fmul, 20 fsgnj, 10 fminmax, 08 fcmp, 04 fclass, 02 fmv_f2i, 01 fmv_i2f
40 0 0 0 3fc00000 40000000 01 1 40400000 00 0
40 0 0 0 3f800001 3f800001 02 2 3f800002 01 0
40 0 3 0 3f800001 3f800001 03 3 3f800003 01 2
40 0 2 0 bf800001 3f800001 04 4 bf800003 01 0
40 0 1 0 3fc00001 3fc00001 05 5 40100001 01 0
40 0 0 0 3f800003 3fc00000 06 6 3fc00004 01 0
40 0 4 0 3f800003 3fc00000 07 7 3fc00005 01 0
40 0 0 0 7f000000 40000000 08 8 7f800000 05 0
40 0 1 0 7f000000 40000000 09 9 7f7fffff 05 0
40 0 2 0 ff000000 40000000 0a a ff800000 05 0
40 0 3 0 ff000000 40000000 0b b ff7fffff 05 1
40 0 0 0 00800000 3f000000 0c c 00000000 03 0
40 0 0 0 7f800000 00000000 0e e 7fc00000 10 0
40 0 0 0 7f800001 3f800000 0f f 7fc00000 10 0
40 0 7 3 3f800001 3f800001 11 1 3f800003 01 0
40 0 7 1 7f000000 40000000 12 2 7f7fffff 05 0
20 0 0 0 3f800000 bf800000 13 3 bf800000 00 0
20 1 0 0 3f800000 bf800000 14 4 3f800000 00 0
20 2 0 0 bf800000 bf800000 15 5 3f800000 00 3
10 0 0 0 3f800000 40000000 16 6 3f800000 00 0
10 1 0 0 3f800000 7f800001 17 7 3f800000 10 0
10 0 0 0 7fc00000 7fc00001 18 8 7fc00000 00 0
10 0 0 0 00000000 80000000 19 9 80000000 00 0
08 2 0 0 3f800000 3f800000 1a a 00000001 00 0
08 1 0 0 3f800000 40000000 1b b 00000001 00 0
08 2 0 0 7fc00000 3f800000 1d d 00000000 00 0
08 2 0 0 7f800001 3f800000 1e e 00000000 10 0
08 1 0 0 7fc00000 3f800000 1f f 00000000 10 2
04 0 0 0 bf800000 00000000 01 0 00000002 00 0
04 0 0 0 7f800001 00000000 02 1 00000100 00 0
02 0 0 0 12345678 00000000 03 2 12345678 00 0
01 0 0 0 ffffffff 00000000 04 3 ffffffff 00 1

// ==== sim.f ====
+incdir+rtl
rtl/fp_fmt_pkg.sv
rtl/fpu_op_pkg.sv
rtl/fpu_ctrl.sv
rtl/fpu_step_cnt.sv
rtl/fp_mul_iter.sv
rtl/fp_cmp_class.sv
rtl/exu_fpu.sv
test/tb_exu_fpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_exu_fpu -o tb_exu_fpu

./obj_dir/tb_exu_fpu | tee sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== test/tb_exu_fpu.sv ====
`timescale 1ns/1ps

module tb_exu_fpu;

    logic                       clk;
    logic                       rst_n;
    logic                       req_fpu_i;
    fpu_op_pkg::fpu_op_t        op_i;
    fpu_op_pkg::sub_op_t        sub_op_i;
    fp_fmt_pkg::fp32_t          op1_i;
    fp_fmt_pkg::fp32_t          op2_i;
    fpu_op_pkg::rm_t            frm_i;
    fpu_op_pkg::rm_t            csr_frm_i;
    fpu_op_pkg::commit_id_t     commit_id_i;
    fpu_op_pkg::reg_addr_t      reg_waddr_i;
    logic                       wb_ready_i;
    logic                       reg_we_o;
    fpu_op_pkg::reg_addr_t      reg_waddr_o;
    fp_fmt_pkg::fp32_t          reg_wdata_o;
    logic                       fcsr_we_o;
    fp_fmt_pkg::fflags_t        fcsr_fflags_o;
    logic                       fflags_pending_o;
    logic                       fpu_stall_o;
    fpu_op_pkg::commit_id_t     commit_id_o;

    int                         fd;
    int                         n_ops;
    int                         n_read;
    string                      line;
    logic [7:0]                 t_op;
    logic [3:0]                 t_sub;
    logic [3:0]                 t_frm;
    logic [3:0]                 t_csr;
    logic [31:0]                t_op1;
    logic [31:0]                t_op2;
    logic [7:0]                 t_waddr;
    logic [3:0]                 t_cid;
    logic [31:0]                t_data;
    logic [7:0]                 t_flags;
    logic [7:0]                 t_bp;

    exu_fpu DUT (.*);

    always #4 clk = ~clk;

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input fp_fmt_pkg::fp32_t got,
                              input fp_fmt_pkg::fp32_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic check_flags(input fp_fmt_pkg::fflags_t got, input fp_fmt_pkg::fflags_t exp);
        if (got !== exp) begin
            $display("MISMATCH fcsr_fflags_o: got %h expected %h", got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic check_tag(input fpu_op_pkg::reg_addr_t got_addr,
                             input fpu_op_pkg::reg_addr_t exp_addr,
                             input fpu_op_pkg::commit_id_t got_id,
                             input fpu_op_pkg::commit_id_t exp_id);
        if (got_addr !== exp_addr || got_id !== exp_id) begin
            $display("MISMATCH reg_waddr_o/commit_id_o: got %h/%h expected %h/%h",
                     got_addr, got_id, exp_addr, exp_id);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // one trace line, from request to write-back handshake
    task automatic run_op();
        int   cycles;
        logic exp_pend;
        exp_pend = |(t_op & 8'h58);
        @(posedge clk);
        req_fpu_i   <= 1'b1;
        op_i        <= fpu_op_pkg::fpu_op_t'(t_op[6:0]);
        sub_op_i    <= t_sub[1:0];
        frm_i       <= fpu_op_pkg::rm_t'(t_frm[2:0]);
        csr_frm_i   <= fpu_op_pkg::rm_t'(t_csr[2:0]);
        op1_i       <= t_op1;
        op2_i       <= t_op2;
        reg_waddr_i <= t_waddr[4:0];
        commit_id_i <= t_cid;
        wb_ready_i  <= (t_bp == 0);
        cycles = 0;
        @(negedge clk);
        while (fpu_stall_o) begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                report_failure("request was never accepted");
            end
        end
        // accept edge, then the held request must see a stall
        @(negedge clk);
        check_bit("fpu_stall_o", fpu_stall_o, 1'b1);
        check_bit("fflags_pending_o", fflags_pending_o, exp_pend);
        @(posedge clk);
        req_fpu_i <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!reg_we_o) begin
            check_bit("fflags_pending_o", fflags_pending_o, exp_pend);
            check_bit("fpu_stall_o", fpu_stall_o, 1'b0);
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                report_failure("reg_we_o did not rise within 100 cycles");
            end
        end
        check_data("reg_wdata_o", reg_wdata_o, t_data);
        check_flags(fcsr_fflags_o, fp_fmt_pkg::fflags_t'(t_flags[4:0]));
        check_bit("fcsr_we_o", fcsr_we_o, |t_flags[4:0]);
        check_tag(reg_waddr_o, t_waddr[4:0], commit_id_o, t_cid);
        for (int i = 0; i < int'(t_bp); i++) begin
            // a new request waits while write-back holds off
            @(posedge clk);
            req_fpu_i <= 1'b1;
            @(negedge clk);
            check_bit("reg_we_o", reg_we_o, 1'b1);
            check_data("reg_wdata_o", reg_wdata_o, t_data);
            check_bit("fflags_pending_o", fflags_pending_o, exp_pend);
            check_bit("fpu_stall_o", fpu_stall_o, 1'b1);
        end
        if (t_bp != 0) begin
            @(posedge clk);
            wb_ready_i <= 1'b1;
            req_fpu_i  <= 1'b0;
        end
        @(posedge clk);
        @(negedge clk);
        check_bit("reg_we_o", reg_we_o, 1'b0);
        check_bit("fflags_pending_o", fflags_pending_o, 1'b0);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_fpu_i   = 1'b0;
        op_i        = '0;
        sub_op_i    = '0;
        op1_i       = '0;
        op2_i       = '0;
        frm_i       = fpu_op_pkg::RNE;
        csr_frm_i   = fpu_op_pkg::RNE;
        commit_id_i = '0;
        reg_waddr_i = '0;
        wb_ready_i  = 1'b1;
        n_ops       = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("reg_we_o", reg_we_o, 1'b0);
        check_bit("fcsr_we_o", fcsr_we_o, 1'b0);
        check_bit("fflags_pending_o", fflags_pending_o, 1'b0);
        check_bit("fpu_stall_o", fpu_stall_o, 1'b0);
        fd = $fopen("test/fpu_trace.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open test/fpu_trace.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == 8'h23) begin
                continue;
            end
            n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", t_op, t_sub, t_frm,
                             t_csr, t_op1, t_op2, t_waddr, t_cid, t_data, t_flags, t_bp);
            if (n_read <= 0) begin
                continue;
            end
            if (n_read != 11) begin
                report_failure("trace line does not hold 11 fields");
            end
            run_op();
            n_ops++;
        end
        $fclose(fd);
        if (n_ops > 0) begin
            $display("%0d operations checked", n_ops);
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("ERROR: trace held no operations");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule

// ==== rtl/exu_fpu.sv ====
`timescale 1ns/1ps
`include "fpu_defs.svh"

module exu_fpu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_fpu_i,
    input  fpu_op_pkg::fpu_op_t    op_i,
    input  fpu_op_pkg::sub_op_t    sub_op_i,
    input  fp_fmt_pkg::fp32_t      op1_i,
    input  fp_fmt_pkg::fp32_t      op2_i,
    input  fpu_op_pkg::rm_t        frm_i,
    input  fpu_op_pkg::rm_t        csr_frm_i,
    input  fpu_op_pkg::commit_id_t commit_id_i,
    input  fpu_op_pkg::reg_addr_t  reg_waddr_i,
    input  logic                   wb_ready_i,
    output logic                   reg_we_o,
    output fpu_op_pkg::reg_addr_t  reg_waddr_o,
    output fp_fmt_pkg::fp32_t      reg_wdata_o,
    output logic                   fcsr_we_o,
    output fp_fmt_pkg::fflags_t    fcsr_fflags_o,
    output logic                   fflags_pending_o,
    output logic                   fpu_stall_o,
    output fpu_op_pkg::commit_id_t commit_id_o
);

    logic                   busy_q;
    logic                   accept;
    logic                   start_q;
    fpu_op_pkg::rm_t        rm_sel;
    fpu_op_pkg::fpu_req_t   req_q;
    logic                   cnt_load;
    logic                   cnt_last;
    logic                   step_en;
    logic                   round;
    logic                   sel_mul;
    logic                   done;
    fp_fmt_pkg::fp_result_t mul_res;
    fp_fmt_pkg::fp_result_t cmp_res;
    fp_fmt_pkg::fp_result_t res_sel;
    logic                   wb_hsk;
    logic                   update;

    assign accept = req_fpu_i && !busy_q;
    assign rm_sel = (frm_i == `RM_DYN) ? csr_frm_i : frm_i;

    // request and tags stay put until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q       <= '{op: op_i, sub_op: sub_op_i, rm: rm_sel, op1: op1_i, op2: op2_i};
            reg_waddr_o <= reg_waddr_i;
            commit_id_o <= commit_id_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
        end
    end

    fpu_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_q),
        .req_i     (req_q),
        .cnt_last_i(cnt_last),
        .cnt_load_o(cnt_load),
        .step_en_o (step_en),
        .round_o   (round),
        .sel_mul_o (sel_mul),
        .done_o    (done)
    );

    fpu_step_cnt u_step_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .cnt_load_i(cnt_load),
        .step_en_i (step_en),
        .cnt_last_o(cnt_last)
    );

    fp_mul_iter u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_i  (req_q),
        .load_i (cnt_load),
        .step_i (step_en),
        .round_i(round),
        .res_o  (mul_res)
    );

    fp_cmp_class u_cmp (
        .req_i(req_q),
        .res_o(cmp_res)
    );

    assign res_sel = sel_mul ? mul_res : cmp_res;
    assign wb_hsk  = reg_we_o && wb_ready_i;
    assign update  = done || wb_hsk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_we_o  <= 1'b0;
            fcsr_we_o <= 1'b0;
        end else if (update) begin
            reg_we_o  <= done;
            fcsr_we_o <= done && (|res_sel.flags);
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            reg_wdata_o   <= res_sel.result;
            fcsr_fflags_o <= res_sel.flags;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (wb_hsk) begin
            busy_q <= 1'b0;
        end
    end

    // only ops that can raise flags hold later fcsr readers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fflags_pending_o <= 1'b0;
        end else if (accept && (op_i.fmul || op_i.fminmax || op_i.fcmp)) begin
            fflags_pending_o <= 1'b1;
        end else if (wb_hsk) begin
            fflags_pending_o <= 1'b0;
        end
    end

    assign fpu_stall_o = busy_q && req_fpu_i;

endmodule

// ==== rtl/fp_cmp_class.sv ====
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fp_cmp_class (
    input  fpu_op_pkg::fpu_req_t   req_i,
    output fp_fmt_pkg::fp_result_t res_o
);

    fp_fmt_pkg::fp32_t   a;
    fp_fmt_pkg::fp32_t   b;
    logic                a_exp_max;
    logic                a_exp_zero;
    logic                a_frac_zero;
    logic                a_nan;
    logic                b_nan;
    logic                a_snan;
    logic                b_snan;
    logic [3:0]          kind;
    fp_fmt_pkg::fclass_t cls;
    logic                both_zero;
    logic                ord_lt;
    logic                eq;
    logic                lt;
    logic                pick_a;
    logic                sgn;

    assign a = req_i.op1;
    assign b = req_i.op2;

    assign a_exp_max   = &a[30:23];
    assign a_exp_zero  = ~|a[30:23];
    assign a_frac_zero = ~|a[22:0];
    assign a_nan       = a_exp_max && !a_frac_zero;
    assign b_nan       = (&b[30:23]) && (b[22:0] != '0);
    assign a_snan      = a_nan && !a[22];
    assign b_snan      = b_nan && !b[22];

    // inf, normal, subnormal, zero
    assign kind = {a_exp_max && a_frac_zero, !a_exp_max && !a_exp_zero,
                   a_exp_zero && !a_frac_zero, a_exp_zero && a_frac_zero};
    // negative categories sit in reverse order
    assign cls  = {a_nan && a[22], a_snan,
                   a[31] ? 4'b0000 : kind,
                   a[31] ? {kind[0], kind[1], kind[2], kind[3]} : 4'b0000};

    // total order with -0 below +0, used by min/max
    always_comb begin
        if (a[31] != b[31]) begin
            ord_lt = a[31];
        end else if (a[31]) begin
            ord_lt = b[30:0] < a[30:0];
        end else begin
            ord_lt = a[30:0] < b[30:0];
        end
    end

    assign both_zero = ~|{a[30:0], b[30:0]};
    assign eq        = (a == b) || both_zero;
    assign lt        = ord_lt && !both_zero;
    assign pick_a    = (req_i.sub_op == fpu_op_pkg::MM_MAX) ? !ord_lt : ord_lt;

    always_comb begin
        case (req_i.sub_op)
            fpu_op_pkg::SGNJ_N: sgn = !b[31];
            fpu_op_pkg::SGNJ_X: sgn = a[31] ^ b[31];
            default:            sgn = b[31];
        endcase
    end

    always_comb begin
        res_o = '0;
        if (req_i.op.fsgnj) begin
            res_o.result = {sgn, a[30:0]};
        end else if (req_i.op.fminmax) begin
            res_o.flags.nv = a_snan || b_snan;
            if (a_nan && b_nan) begin
                res_o.result = `FP_QNAN;
            end else if (a_nan) begin
                res_o.result = b;
            end else if (b_nan) begin
                res_o.result = a;
            end else begin
                res_o.result = pick_a ? a : b;
            end
        end else if (req_i.op.fcmp) begin
            if (a_nan || b_nan) begin
                // feq is quiet, flt and fle signal on any nan
                res_o.flags.nv = (req_i.sub_op == fpu_op_pkg::CMP_EQ) ? (a_snan || b_snan) : 1'b1;
            end else if (req_i.sub_op == fpu_op_pkg::CMP_EQ) begin
                res_o.result = {31'd0, eq};
            end else if (req_i.sub_op == fpu_op_pkg::CMP_LT) begin
                res_o.result = {31'd0, lt};
            end else begin
                res_o.result = {31'd0, lt || eq};
            end
        end else if (req_i.op.fclass) begin
            res_o.result = {22'd0, cls};
        end else if (req_i.op.fmv_f2i || req_i.op.fmv_i2f) begin
            // raw bit move
            res_o.result = a;
        end
    end

endmodule

// ==== rtl/fp_mul_iter.sv ====
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fp_mul_iter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fpu_op_pkg::fpu_req_t   req_i,
    input  logic                   load_i,
    input  logic                   step_i,
    input  logic                   round_i,
    output fp_fmt_pkg::fp_result_t res_o
);

    fp_fmt_pkg::exp_t       exp_a;
    fp_fmt_pkg::exp_t       exp_b;
    fp_fmt_pkg::mant_t      mant_a;
    fp_fmt_pkg::mant_t      mant_b;
    logic                   a_zero;
    logic                   b_zero;
    logic                   a_inf;
    logic                   b_inf;
    logic                   a_nan;
    logic                   b_nan;
    logic                   inf_zero;
    logic                   sign_p;
    logic                   spec_nv;
    logic                   spec_hit;
    fp_fmt_pkg::fp32_t      spec_val;

    logic                   sign_q;
    logic signed [9:0]      exp_q;
    fp_fmt_pkg::mant_t      mcand_q;
    logic [47:0]            prod_q;
    logic                   spec_q;
    logic                   spec_nv_q;
    fp_fmt_pkg::fp32_t      spec_val_q;
    fp_fmt_pkg::fp_result_t res_q;

    logic [24:0]            sum_hi;
    fp_fmt_pkg::mant_t      mant_n;
    logic                   grd;
    logic                   stk;
    logic                   inc;
    logic [24:0]            mant_rnd;
    logic signed [9:0]      exp_n;
    logic signed [9:0]      exp_fin;
    logic                   ovf_max;
    fp_fmt_pkg::fp_result_t res_d;

    assign exp_a  = req_i.op1[30:23];
    assign exp_b  = req_i.op2[30:23];
    assign mant_a = {1'b1, req_i.op1[22:0]};
    assign mant_b = {1'b1, req_i.op2[22:0]};

    // subnormal inputs count as zero
    assign a_zero   = (exp_a == 8'h00);
    assign b_zero   = (exp_b == 8'h00);
    assign a_inf    = (exp_a == 8'hff) && (req_i.op1[22:0] == '0);
    assign b_inf    = (exp_b == 8'hff) && (req_i.op2[22:0] == '0);
    assign a_nan    = (exp_a == 8'hff) && (req_i.op1[22:0] != '0);
    assign b_nan    = (exp_b == 8'hff) && (req_i.op2[22:0] != '0);
    assign inf_zero = (a_inf && b_zero) || (a_zero && b_inf);
    assign sign_p   = req_i.op1[31] ^ req_i.op2[31];
    assign spec_nv  = (a_nan && !req_i.op1[22]) || (b_nan && !req_i.op2[22]) || inf_zero;

    always_comb begin
        spec_hit = 1'b1;
        if (a_nan || b_nan || inf_zero) begin
            spec_val = `FP_QNAN;
        end else if (a_inf || b_inf) begin
            spec_val = {sign_p, 8'hff, 23'd0};
        end else if (a_zero || b_zero) begin
            spec_val = {sign_p, 31'd0};
        end else begin
            spec_val = '0;
            spec_hit = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_q    <= 1'b0;
            spec_nv_q <= 1'b0;
        end else if (load_i) begin
            spec_q    <= spec_hit;
            spec_nv_q <= spec_nv;
        end
    end

    // multiplier sits in the low half and shifts out lsb first
    assign sum_hi = {1'b0, prod_q[47:24]} + (prod_q[0] ? {1'b0, mcand_q} : 25'd0);

    always_ff @(posedge clk) begin
        if (load_i) begin
            sign_q     <= sign_p;
            exp_q      <= {2'b00, exp_a} + {2'b00, exp_b} - 10'd127;
            mcand_q    <= mant_a;
            prod_q     <= {24'd0, mant_b};
            spec_val_q <= spec_val;
        end else if (step_i) begin
            prod_q <= {sum_hi, prod_q[23:1]};
        end
        if (round_i) begin
            res_q <= res_d;
        end
    end

    always_comb begin
        if (prod_q[47]) begin
            mant_n = prod_q[47:24];
            grd    = prod_q[23];
            stk    = |prod_q[22:0];
        end else begin
            mant_n = prod_q[46:23];
            grd    = prod_q[22];
            stk    = |prod_q[21:0];
        end
        case (req_i.rm)
            fpu_op_pkg::RNE: inc = grd && (stk || mant_n[0]);
            fpu_op_pkg::RDN: inc = sign_q && (grd || stk);
            fpu_op_pkg::RUP: inc = !sign_q && (grd || stk);
            fpu_op_pkg::RMM: inc = grd;
            default:         inc = 1'b0;
        endcase
        mant_rnd = {1'b0, mant_n} + 25'(inc);
        exp_n    = exp_q + 10'(prod_q[47]);
        // a carry out leaves the fraction at zero
        exp_fin  = exp_n + 10'(mant_rnd[24]);
        ovf_max  = (req_i.rm == fpu_op_pkg::RTZ)
                || ((req_i.rm == fpu_op_pkg::RDN) && !sign_q)
                || ((req_i.rm == fpu_op_pkg::RUP) && sign_q);

        res_d = '0;
        if (spec_q) begin
            res_d.result   = spec_val_q;
            res_d.flags.nv = spec_nv_q;
        end else if (exp_n < 10'sd1) begin
            // flush tiny results
            res_d.result   = {sign_q, 31'd0};
            res_d.flags.uf = 1'b1;
            res_d.flags.nx = 1'b1;
        end else if (exp_fin > 10'sd254) begin
            res_d.result   = ovf_max ? {sign_q, 8'hfe, 23'h7f_ffff} : {sign_q, 8'hff, 23'd0};
            res_d.flags.of = 1'b1;
            res_d.flags.nx = 1'b1;
        end else begin
            res_d.result   = {sign_q, exp_fin[7:0], mant_rnd[22:0]};
            res_d.flags.nx = grd || stk;
        end
    end

    assign res_o = res_q;

endmodule

// ==== rtl/fpu_step_cnt.sv ====
`timescale 1ns/1ps
`include "fpu_defs.svh"

module fpu_step_cnt (
    input  logic clk,
    input  logic rst_n,
    input  logic cnt_load_i,
    input  logic step_en_i,
    output logic cnt_last_o
);

    localparam int CNT_W = $clog2(`MUL_STEPS);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (cnt_load_i) begin
            cnt_q <= CNT_W'(`MUL_STEPS - 1);
        end else if (step_en_i && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign cnt_last_o = (cnt_q == '0);

endmodule

// ==== rtl/fpu_ctrl.sv ====
`timescale 1ns/1ps

module fpu_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  fpu_op_pkg::fpu_req_t req_i,
    input  logic                 cnt_last_i,
    output logic                 cnt_load_o,
    output logic                 step_en_o,
    output logic                 round_o,
    output logic                 sel_mul_o,
    output logic                 done_o
);

    fpu_op_pkg::ctrl_state_t state_q;
    fpu_op_pkg::ctrl_state_t state_d;
    logic                    short_done;

    assign cnt_load_o = (state_q == fpu_op_pkg::IDLE) && start_i && req_i.op.fmul;
    assign step_en_o  = (state_q == fpu_op_pkg::MUL);
    assign round_o    = (state_q == fpu_op_pkg::ROUND);

    // everything but fmul finishes straight from idle
    assign short_done = (state_q == fpu_op_pkg::IDLE) && start_i && !req_i.op.fmul;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fpu_op_pkg::IDLE: begin
                if (cnt_load_o) begin
                    state_d = fpu_op_pkg::MUL;
                end
            end
            fpu_op_pkg::MUL: begin
                // last step still runs in this cycle
                if (cnt_last_i) begin
                    state_d = fpu_op_pkg::ROUND;
                end
            end
            default: begin
                state_d = fpu_op_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= fpu_op_pkg::IDLE;
            done_o    <= 1'b0;
            sel_mul_o <= 1'b0;
        end else begin
            state_q   <= state_d;
            done_o    <= short_done || round_o;
            sel_mul_o <= round_o;
        end
    end

endmodule

// ==== rtl/fpu_op_pkg.sv ====
`include "fpu_defs.svh"

package fpu_op_pkg;

    // one-hot operation select
    typedef struct packed {
        logic fmul;
        logic fsgnj;
        logic fminmax;
        logic fcmp;
        logic fclass;
        logic fmv_f2i;
        logic fmv_i2f;
    } fpu_op_t;

    // variant select, encoded like funct3
    typedef logic [1:0] sub_op_t;

    localparam sub_op_t SGNJ_J = 2'd0;
    localparam sub_op_t SGNJ_N = 2'd1;
    localparam sub_op_t SGNJ_X = 2'd2;
    localparam sub_op_t MM_MIN = 2'd0;
    localparam sub_op_t MM_MAX = 2'd1;
    localparam sub_op_t CMP_LE = 2'd0;
    localparam sub_op_t CMP_LT = 2'd1;
    localparam sub_op_t CMP_EQ = 2'd2;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } rm_t;

    typedef logic [`REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [`COMMIT_ID_WIDTH-1:0] commit_id_t;

    typedef struct packed {
        fpu_op_t           op;
        sub_op_t           sub_op;
        rm_t               rm;
        fp_fmt_pkg::fp32_t op1;
        fp_fmt_pkg::fp32_t op2;
    } fpu_req_t;

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        ROUND
    } ctrl_state_t;

endpackage

// ==== rtl/fp_fmt_pkg.sv ====
`include "fpu_defs.svh"

package fp_fmt_pkg;

    typedef logic [`FLEN-1:0] fp32_t;

    // biased exponent
    typedef logic [7:0] exp_t;

    // mantissa with the hidden bit
    typedef logic [23:0] mant_t;

    // same bit order as fcsr.fflags
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // one bit per fclass category, bit 0 is -inf
    typedef logic [9:0] fclass_t;

    typedef struct packed {
        fp32_t   result;
        fflags_t flags;
    } fp_result_t;

endpackage

// ==== rtl/fpu_defs.svh ====
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// register data width
`define FLEN            32
`define REG_ADDR_WIDTH  5
`define COMMIT_ID_WIDTH 4

// mantissa bits multiplied, hidden bit included
`define MUL_STEPS       24

// frm value that defers to the csr rounding mode
`define RM_DYN          3'b111

// canonical quiet nan
`define FP_QNAN         32'h7fc0_0000

`endif
